/* logic/accumPkg.sv */
`default_nettype none

package accumPkg;

	// IEEE half-precision field layout
	localparam int ExpBits = 5;
	localparam int ManBits = 10;
	localparam int ExpBias = 15;     // Largest finite exponent is 2*ExpBias
	localparam int GrsBits = 3;      // Guard, round, sticky

	// Adder pipeline depth and per-element cost
	localparam int AddLatency = 4;   // Align, add, normalize, round
	localparam int ElemCycles = AddLatency + 2; // Plus Read and Load

	typedef logic [ExpBits-1:0] expT;

	// Sign, biased exponent, stored mantissa
	typedef struct packed {
		logic sign;
		expT exp;
		logic [ManBits-1:0] man;
	} halfT;

	// Carry, hidden bit, mantissa, then GRS at the bottom
	typedef logic [ManBits+GrsBits+1:0] wideManT;

	// Block controller states
	typedef enum logic [2:0] {
		Idle,     // Waiting for start
		Read,     // Memory strobe or completion
		Load,     // Word on memData, operands enter adder
		Wait,     // Adder in flight
		Update    // Sum takes adder result
	} ctrlStateT;

endpackage

`default_nettype wire

/* logic/halfAlign.sv */
`timescale 1ns/1ns
`default_nettype none

module halfAlign import accumPkg::*; (
	input logic ap_clk,
	input halfT opA,
	input halfT opB,
	output logic alnSign,    // Sign of the larger operand
	output logic alnSub,     // Signs differ, effective subtract
	output expT alnExp,      // Common exponent
	output wideManT alnBig,  // Larger mantissa, unshifted
	output wideManT alnSmall // Smaller mantissa, shifted with sticky
);

	localparam int ManW = $bits(wideManT);

	logic [ExpBits+ManBits-1:0] magA;   // Magnitude with zero exponent forced to zero
	logic [ExpBits+ManBits-1:0] magB;
	logic aBig;
	expT bigExp;
	expT smallExp;
	expT shiftAmt;
	logic [ManBits-1:0] bigMan;
	logic [ManBits-1:0] smallMan;
	wideManT smallPre;
	logic [2*ManW-1:0] smallExt;        // Upper half is result, lower half feeds sticky
	logic signSel;

	// No subnormals, zero exponent means zero
	assign magA = (opA.exp == '0) ? '0 : {opA.exp, opA.man};
	assign magB = (opB.exp == '0) ? '0 : {opB.exp, opB.man};
	assign aBig = magA >= magB;         // Tie picks A

	assign {bigExp, bigMan} = aBig ? magA : magB;
	assign {smallExp, smallMan} = aBig ? magB : magA;
	assign shiftAmt = bigExp - smallExp; // Never negative

	// Hidden bit only on a nonzero exponent
	assign smallPre = {1'b0, smallExp != '0, smallMan, {GrsBits{1'b0}}};
	assign smallExt = {smallPre, {ManW{1'b0}}} >> shiftAmt;

	// Exact cancellation lands on +0
	always_comb begin
		if (magA == magB && opA.sign != opB.sign) begin
			signSel = 1'b0;
		end else begin
			signSel = aBig ? opA.sign : opB.sign;
		end
	end

	always_ff @(posedge ap_clk) begin
		alnSign <= signSel;
		alnSub <= opA.sign ^ opB.sign;
		alnExp <= bigExp;
		alnBig <= {1'b0, bigExp != '0, bigMan, {GrsBits{1'b0}}};
		// Everything below the window ORs into sticky
		alnSmall <= {smallExt[2*ManW-1:ManW+1], smallExt[ManW] | (|smallExt[ManW-1:0])};
	end

endmodule

`default_nettype wire

/* logic/halfMantAdd.sv */
`timescale 1ns/1ns
`default_nettype none

module halfMantAdd import accumPkg::*; (
	input logic ap_clk,
	input logic alnSign,
	input logic alnSub,
	input expT alnExp,
	input wideManT alnBig,
	input wideManT alnSmall,
	output logic addSign,
	output expT addExp,
	output wideManT addSum   // Top bit set on carry out
);

	wideManT sumNext;

	// Larger operand first, so the difference stays positive
	always_comb begin
		if (alnSub) begin
			sumNext = alnBig - alnSmall;
		end else begin
			sumNext = alnBig + alnSmall; // Carry bit has room
		end
	end

	always_ff @(posedge ap_clk) begin
		addSign <= alnSign;   // Sign of larger operand
		addExp <= alnExp;
		addSum <= sumNext;
	end

endmodule

`default_nettype wire

/* logic/halfNormalize.sv */
`timescale 1ns/1ns
`default_nettype none

module halfNormalize import accumPkg::*; (
	input logic ap_clk,
	input logic addSign,
	input expT addExp,
	input wideManT addSum,
	output logic normSign,
	output logic [ExpBits:0] normExp, // Extra bit for overflow after carry
	output wideManT normMan,          // Hidden bit back at its home position
	output logic normZero             // Zero sum or underflow
);

	localparam int TopBit = ManBits + GrsBits;   // Hidden bit position
	localparam int LzW = $clog2(TopBit + 2);

	logic carry;
	logic sumZero;
	logic expLow;
	logic [LzW-1:0] lzCnt;
	logic signed [ExpBits+1:0] expWork;   // Signed so underflow shows
	wideManT manWork;

	assign carry = addSum[TopBit+1];
	assign sumZero = addSum == '0;

	// Leading zeros below the carry bit, highest one wins
	always_comb begin
		lzCnt = LzW'(TopBit + 1);
		for (int i = 0; i <= TopBit; i++) begin
			if (addSum[i]) begin
				lzCnt = LzW'(TopBit - i);
			end
		end
	end

	always_comb begin
		if (carry) begin
			// One step right, dropped bit folds into sticky
			manWork = {1'b0, addSum[TopBit+1:2], addSum[1] | addSum[0]};
			expWork = {2'b00, addExp} + 1'b1;
		end else begin
			manWork = addSum << lzCnt;
			expWork = {2'b00, addExp} - lzCnt;
		end
	end

	assign expLow = expWork <= 0;   // Would be subnormal, flushed

	always_ff @(posedge ap_clk) begin
		// Underflow only follows cancellation, so that zero is positive
		normSign <= addSign & (sumZero | ~expLow);
		normExp <= expWork[ExpBits:0];
		normMan <= manWork;
		normZero <= sumZero | expLow;
	end

endmodule

`default_nettype wire

/* logic/halfRound.sv */
`timescale 1ns/1ns
`default_nettype none

module halfRound import accumPkg::*; (
	input logic ap_clk,
	input logic normSign,
	input logic [ExpBits:0] normExp,
	input wideManT normMan,
	input logic normZero,
	output halfT addResult
);

	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic roundUp;
	logic [ManBits+1:0] manRnd;   // Carry, hidden, stored mantissa
	logic [ExpBits:0] expRnd;
	halfT resNext;

	assign guardBit = normMan[GrsBits-1];
	assign roundBit = normMan[GrsBits-2];
	assign stickyBit = |normMan[GrsBits-3:0];

	// Nearest even, a tie only rounds up from an odd lsb
	assign roundUp = guardBit & (roundBit | stickyBit | normMan[GrsBits]);
	assign manRnd = {1'b0, normMan[ManBits+GrsBits:GrsBits]} + roundUp;
	assign expRnd = normExp + manRnd[ManBits+1]; // Mantissa wrapped to 1.0

	always_comb begin
		resNext.sign = normSign;
		resNext.exp = expRnd[ExpBits-1:0];
		resNext.man = manRnd[ManBits-1:0];   // Already zero after a wrap
		if (normZero) begin
			resNext.exp = '0;
			resNext.man = '0;
		end else if (expRnd > (ExpBits + 1)'(2 * ExpBias)) begin
			// Saturate to signed infinity
			resNext.exp = '1;
			resNext.man = '0;
		end
	end

	always_ff @(posedge ap_clk) begin
		addResult <= resNext;
	end

endmodule

`default_nettype wire

/* logic/accumControl.sv */
`timescale 1ns/1ns
`default_nettype none

module accumControl import accumPkg::*; #(
	parameter int NumElems = 16,
	localparam int AddrW = (NumElems > 1) ? $clog2(NumElems) : 1
) (
	input logic ap_clk,
	input logic ap_rst,
	input logic apStart,
	input logic apContinue,
	output logic apDone,
	output logic apIdle,
	output logic apReady,
	output logic [AddrW-1:0] memAddr,
	output logic memEn,
	input halfT memData,     // Valid the cycle after memEn
	output halfT opA,
	output halfT opB,
	input halfT addResult,
	output halfT sumOut,
	output logic sumVld
);

	localparam int IdxW = $clog2(NumElems + 1);   // Index must reach NumElems
	localparam int PhaseW = $clog2(ElemCycles);

	ctrlStateT state;
	ctrlStateT stateNext;
	logic [IdxW-1:0] elemIdx;
	logic [PhaseW-1:0] phase;   // Cycle within the element, Read is 0
	logic startOk;
	logic finish;               // Final Read, all elements summed
	logic doneReg;              // Done held until continue
	halfT sumReg;
	halfT holdReg;              // Last completed sum

	assign startOk = state == Idle && apStart && !doneReg;
	assign finish = state == Read && elemIdx == IdxW'(NumElems);

	always_comb begin
		stateNext = state;
		case (state)
			Idle: begin
				if (startOk) begin
					stateNext = Read;
				end
			end
			Read: stateNext = finish ? Idle : Load;
			Load: stateNext = Wait;
			Wait: begin
				// Update lines up with the adder result
				if (phase == PhaseW'(ElemCycles - 2)) begin
					stateNext = Update;
				end
			end
			Update: stateNext = Read;
			default: stateNext = Idle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= Idle;
			elemIdx <= '0;
			phase <= '0;
			doneReg <= 1'b0;
			holdReg <= '0;
		end else begin
			state <= stateNext;
			phase <= (state == Read) ? PhaseW'(1) : phase + 1'b1;
			if (startOk) begin
				elemIdx <= '0;
			end else if (state == Update) begin
				elemIdx <= elemIdx + 1'b1;
			end
			// Continue wins over a new completion
			if (apContinue) begin
				doneReg <= 1'b0;
			end else if (finish) begin
				doneReg <= 1'b1;
			end
			if (finish) begin
				holdReg <= sumReg;
			end
		end
	end

	// Running sum
	always_ff @(posedge ap_clk) begin
		if (startOk) begin
			sumReg <= '0;   // Positive zero
		end else if (state == Update) begin
			sumReg <= addResult;
		end
	end

	assign memEn = state == Read && !finish;
	assign memAddr = elemIdx[AddrW-1:0];

	// Operands enter the adder in Load, zero word otherwise
	assign opA = sumReg;
	assign opB = (state == Load) ? memData : '0;

	assign sumOut = finish ? sumReg : holdReg;
	assign sumVld = finish;
	assign apDone = finish | doneReg;
	assign apReady = finish;
	assign apIdle = state == Idle && !apStart;

endmodule

`default_nettype wire

/* logic/accumTop.sv */
`timescale 1ns/1ns
`default_nettype none

module accumTop import accumPkg::*; #(
	parameter int NumElems = 16,
	localparam int AddrW = (NumElems > 1) ? $clog2(NumElems) : 1
) (
	input logic ap_clk,
	input logic ap_rst,
	input logic apStart,
	input logic apContinue,
	output logic apDone,
	output logic apIdle,
	output logic apReady,
	output logic [AddrW-1:0] memAddr,
	output logic memEn,
	input halfT memData,
	output halfT sumOut,
	output logic sumVld
);

	halfT opA;             // Running sum
	halfT opB;             // Word from memory
	halfT addResult;

	// Stage 1 to 2
	logic alnSign;
	logic alnSub;
	expT alnExp;
	wideManT alnBig;
	wideManT alnSmall;

	// Stage 2 to 3
	logic addSign;
	expT addExp;
	wideManT addSum;

	// Stage 3 to 4
	logic normSign;
	logic [ExpBits:0] normExp;
	wideManT normMan;
	logic normZero;

	accumControl #(
		.NumElems(NumElems)
	) ctrl0 (
		.ap_clk,
		.ap_rst,
		.apStart,
		.apContinue,
		.apDone,
		.apIdle,
		.apReady,
		.memAddr,
		.memEn,
		.memData,
		.opA,
		.opB,
		.addResult,
		.sumOut,
		.sumVld
	);

	// Four-stage adder, one pair per cycle
	halfAlign align0 (
		.ap_clk,
		.opA,
		.opB,
		.alnSign,
		.alnSub,
		.alnExp,
		.alnBig,
		.alnSmall
	);

	halfMantAdd mant0 (
		.ap_clk,
		.alnSign,
		.alnSub,
		.alnExp,
		.alnBig,
		.alnSmall,
		.addSign,
		.addExp,
		.addSum
	);

	halfNormalize norm0 (
		.ap_clk,
		.addSign,
		.addExp,
		.addSum,
		.normSign,
		.normExp,
		.normMan,
		.normZero
	);

	halfRound round0 (
		.ap_clk,
		.normSign,
		.normExp,
		.normMan,
		.normZero,
		.addResult     // Back to the controller
	);

endmodule

`default_nettype wire

/* dv/accumTb.sv */
`timescale 1ns/1ns
`default_nettype none

module accumTb;

	localparam int NumElems = 16;
	localparam int NumTests = 8;
	localparam int WordsPerTest = NumElems + 2;   // Number, words, expected sum
	localparam int ExpLatency = 1 + NumElems * 6; // Read, Load, four adder cycles
	localparam int Timeout = 200;
	localparam int HoldCycles = 12;

	logic ap_clk;
	logic ap_rst;
	logic apStart;
	logic apContinue;
	logic apDone;
	logic apIdle;
	logic apReady;
	logic [3:0] memAddr;
	logic memEn;
	logic [15:0] memData;
	logic [15:0] sumOut;
	logic sumVld;

	logic [15:0] stimArr [0:NumTests*WordsPerTest-1];
	logic [15:0] memArr [0:NumElems-1];   // Current test vector
	logic rdEn;
	logic [3:0] rdAddr;
	logic [15:0] lastSum;                 // Sum of the previous completion
	int cycleCnt = 0;
	int errCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	bit aborted = 0;
	integer seed;

	accumTop #(
		.NumElems(NumElems)
	) dut0 (
		.ap_clk,
		.ap_rst,
		.apStart,
		.apContinue,
		.apDone,
		.apIdle,
		.apReady,
		.memAddr,
		.memEn,
		.memData(memData),
		.sumOut(sumOut),
		.sumVld
	);

	initial ap_clk = 1'b0;
	always #4 ap_clk = ~ap_clk;   // 8 ns period

	always @(posedge ap_clk) cycleCnt <= cycleCnt + 1;

	// Single-port memory, data one cycle after the strobe
	always begin
		@(negedge ap_clk);
		rdEn = memEn;
		rdAddr = memAddr;
		@(posedge ap_clk);
		#1;
		if (rdEn) memData = memArr[rdAddr];
	end

	function automatic string testName(input int idx);
		case (idx)
			0: return "integers";
			1: return "fractions";
			2: return "cancel";
			3: return "ties";
			4: return "roundUp";
			5: return "posOverflow";
			6: return "negOverflow";
			default: return "zeroExp";
		endcase
	endfunction

	task automatic checkEq(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %h actual %h", what, expected, actual);
			errCount++;
		end
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		testsRun++;
		if (errCount == errBefore) begin
			$display("Test %0d %s passed", num, name);
		end else begin
			testsFailed++;
			$display("Test %0d %s failed", num, name);
		end
	endtask

	task automatic waitIdle(output bit ok);
		int waitCnt;
		waitCnt = 0;
		ok = 0;
		while (!ok && waitCnt < Timeout) begin
			@(negedge ap_clk);
			ok = apIdle;
			waitCnt++;
		end
		if (!ok) begin
			$display("Timed out waiting for the DUT to go idle");
			errCount++;
			aborted = 1;
		end
	endtask

	task automatic runVector(input int idx, input bit holdDone);
		int base;
		int errBefore;
		int gap;
		int reads;
		int startCycle;
		int waitCnt;
		bit seen;
		bit ok;
		string name;
		logic [15:0] expSum;
		base = idx * WordsPerTest;
		errBefore = errCount;
		name = testName(idx);
		checkEq({name, " number"}, idx + 1, stimArr[base]);
		for (int i = 0; i < NumElems; i++) memArr[i] = stimArr[base + 1 + i];
		expSum = stimArr[base + NumElems + 1];
		gap = $unsigned($random(seed)) % 4;   // Idle gap before start
		repeat (gap) @(posedge ap_clk);
		waitIdle(ok);
		if (!ok) return;
		@(posedge ap_clk);
		#1;
		apContinue = !holdDone;
		apStart = 1'b1;
		startCycle = cycleCnt;   // Idle cycle that takes the start
		@(posedge ap_clk);
		#1;
		apStart = 1'b0;
		reads = 0;
		seen = 0;
		waitCnt = 0;
		while (!seen && waitCnt < Timeout) begin
			@(negedge ap_clk);
			if (memEn) begin
				checkEq({name, " address"}, reads, memAddr);   // Steps 0 upward
				reads++;
			end
			seen = sumVld;
			if (!seen) begin
				// Handshake quiet and old sum held until the final Read
				checkEq({name, " early done"}, 0, apDone);
				checkEq({name, " early ready"}, 0, apReady);
				checkEq({name, " sum during run"}, lastSum, sumOut);
			end
			waitCnt++;
		end
		if (!seen) begin
			$display("Timed out waiting for the sum of test %s", name);
			errCount++;
			aborted = 1;
			return;
		end
		checkEq({name, " latency"}, ExpLatency, cycleCnt - startCycle);
		checkEq({name, " sum"}, expSum, sumOut);
		checkEq({name, " done"}, 1, apDone);
		checkEq({name, " ready"}, 1, apReady);
		checkEq({name, " reads"}, NumElems, reads);
		lastSum = expSum;
		@(negedge ap_clk);
		checkEq({name, " valid pulse"}, 0, sumVld);   // One cycle only
		checkEq({name, " ready pulse"}, 0, apReady);
		checkEq({name, " held sum"}, expSum, sumOut);
		if (holdDone) begin
			// Done pending, start must be ignored
			@(posedge ap_clk);
			#1;
			apStart = 1'b1;
			repeat (HoldCycles) begin
				@(negedge ap_clk);
				checkEq({name, " done held"}, 1, apDone);
				checkEq({name, " no read"}, 0, memEn);
				checkEq({name, " sum held"}, expSum, sumOut);
			end
			@(posedge ap_clk);
			#1;
			apStart = 1'b0;
			apContinue = 1'b1;
			@(posedge ap_clk);
			@(negedge ap_clk);
			checkEq({name, " done cleared"}, 0, apDone);
			checkEq({name, " sum after continue"}, expSum, sumOut);
		end
		reportTest(idx + 1, name, errBefore);
	endtask

	initial begin
		int errBefore;
		seed = 20894;
		ap_rst = 1'b1;
		apStart = 1'b0;
		apContinue = 1'b1;
		memData = '0;
		rdEn = 1'b0;
		rdAddr = '0;
		lastSum = '0;   // Output register clears on reset
		$readmemh("dv/accumStim.mem", stimArr);
		if (stimArr[0] === 16'hxxxx) begin
			$display("Stimulus file dv/accumStim.mem could not be read");
			errCount++;
			aborted = 1;
		end
		repeat (16) @(posedge ap_clk);
		#1;
		ap_rst = 1'b0;
		@(negedge ap_clk);
		// Quiet outputs straight after reset
		errBefore = errCount;
		checkEq("reset done", 0, apDone);
		checkEq("reset ready", 0, apReady);
		checkEq("reset valid", 0, sumVld);
		checkEq("reset memEn", 0, memEn);
		checkEq("reset sum", 0, sumOut);
		checkEq("reset idle", 1, apIdle);
		reportTest(0, "reset", errBefore);
		for (int t = 0; t < NumTests; t++) begin
			if (!aborted) runVector(t, t == 1);   // Second vector exercises back-pressure
		end
		$display("Tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed,
			errCount);
		if (errCount == 0 && !aborted) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/accumStim.mem */
// Each test: test number, 16 half-precision input words, expected sum
// All values hex, summed in order from +0 with round to nearest even
// integers 1 to 16
0001 3C00 4000 4200 4400 4500 4600 4700 4800
4880 4900 4980 4A00 4A80 4B00 4B80 4C00 5840
// halves and quarters
0002 3800 3800 3800 3800 3800 3800 3800 3800
3400 3400 3400 3400 3400 3400 3400 3400 4600
// mixed signs cancelling to +0
0003 C200 4200 3C00 BA00 B400 4100 C100 BC00
3800 3800 4500 C500 4800 C400 C200 BC00 0000
// ties near 2048
0004 6801 3C00 3C00 3C00 3C00 3C00 3C00 3C00
3C00 3C00 3C00 3C00 3C00 3C00 3C00 3C00 6802
// 0.75 steps above 1024 round up
0005 6400 3A00 3A00 3A00 3A00 3A00 3A00 3A00
3A00 3A00 3A00 3A00 3A00 3A00 3A00 3A00 640F
// positive overflow
0006 7800 7800 3C00 3C00 3C00 3C00 3C00 3C00
3C00 3C00 3C00 3C00 3C00 3C00 3C00 3C00 7C00
// negative overflow
0007 F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800 FC00
// zero exponent words count as zero
0008 3C00 03FF 4000 0001 8200 3C00 0000 8000
83FF 0155 4400 02AA 0001 8001 4800 0100 4C00

/* files.f */
logic/accumPkg.sv
logic/halfAlign.sv
logic/halfMantAdd.sv
logic/halfNormalize.sv
logic/halfRound.sv
logic/accumControl.sv
logic/accumTop.sv
dv/accumTb.sv

/* Bender.yml */
package:
  name: accum

sources:
  - logic/accumPkg.sv
  - logic/halfAlign.sv
  - logic/halfMantAdd.sv
  - logic/halfNormalize.sv
  - logic/halfRound.sv
  - logic/accumControl.sv
  - logic/accumTop.sv
  - target: simulation
    files:
      - dv/accumTb.sv
